//--- sd_cmd_phy.f
source/sd_cmd_pkg.sv
source/sd_line_pkg.sv
source/sd_crc7.sv
source/sd_cmd_tx.sv
source/sd_rsp_rx.sv
source/sd_cmd_ctrl.sv
source/sd_cmd_phy.sv
tb/sd_cmd_phy_asserts.sv
tb/sd_cmd_phy_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the CMD phy testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module sd_cmd_phy_tb \
  -f sd_cmd_phy.f \
  -o sd_cmd_phy_sim

# A $fatal or failed assertion gives a nonzero exit status
./obj_dir/sd_cmd_phy_sim

//--- tb/sd_cmd_phy_tb.sv
`timescale 1ns/1ps
// Drives sd_cmd_phy against a simple SD card model on the CMD line
// Inputs change on the falling edge and outputs are sampled there too
module sd_cmd_phy_tb
  import sd_cmd_pkg::*;
  import sd_line_pkg::*;
();

  localparam int TURN_CYCLES = 2;
  localparam int CLK_PERIOD = 40;
  localparam int NUM_TESTS = 9;
  localparam int MAX_DELAY = 7;
  // Command, turnaround, card delay, longest reply and handshake slack
  localparam int TEST_CYCLES = CMD_FRAME_BITS + TURN_CYCLES + MAX_DELAY + RSP_LONG_BITS + 16;
  localparam int WATCHDOG_NS = 2 * NUM_TESTS * TEST_CYCLES * CLK_PERIOD;
  localparam logic [31:0] SEED = 32'hee65_6d20;

  logic        sd_clk;
  logic        rst;
  logic        cmd_en;
  sd_cmd_t     cmd;
  logic        rsp_long;
  sd_line_t    cmd_line;
  logic        sd_cmd;
  sd_rsp_t     rsp;
  logic        rsp_done;
  logic [31:0] lcg_state;

  sd_cmd_phy #(
    .TURN_CYCLES (TURN_CYCLES)
  ) sd_cmd_phy_i (
    .i_sd_clk   (sd_clk),
    .rst        (rst),
    .i_cmd_en   (cmd_en),
    .i_cmd      (cmd),
    .i_rsp_long (rsp_long),
    .o_cmd_line (cmd_line),
    .i_sd_cmd   (sd_cmd),
    .o_rsp      (rsp),
    .o_rsp_done (rsp_done)
  );

  initial begin
    sd_clk = 1'b0;
    forever #(CLK_PERIOD / 2) sd_clk = ~sd_clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("SIMULATION FAILED");
    $fatal(1, "watchdog expired");
  end

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // CRC7 over the top count bits of a left aligned vector
  function automatic logic [CRC7_BITS-1:0] crc7_over(input logic [RSP_LONG_BITS-1:0] bits,
                                                     input int count);
    logic [CRC7_BITS-1:0]     crc;
    logic [RSP_LONG_BITS-1:0] rest;
    logic                     fb;
    crc = '0;
    rest = bits;
    repeat (count) begin
      fb = crc[CRC7_BITS-1] ^ rest[RSP_LONG_BITS-1];
      // x^7 + x^3 + 1
      crc = {crc[CRC7_BITS-2:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
      rest = rest << 1;
    end
    return crc;
  endfunction

  // Covered bits run from top down to 8 and the CRC lands in 7:1 above the end bit
  function automatic logic [RSP_LONG_BITS-1:0] with_crc(input logic [RSP_LONG_BITS-1:0] frame,
                                                        input int top);
    logic [RSP_LONG_BITS-1:0] framed;
    framed = frame;
    framed[7:0] = {crc7_over(frame << (RSP_LONG_BITS - 1 - top), top - 7), 1'b1};
    return framed;
  endfunction

  task automatic expect_true(input logic ok, input string what);
    assert (ok) else begin
      $display("mismatch at %0d ns: %s", $time, what);
      $display("SIMULATION FAILED");
      $fatal(1, "value check failed");
    end
  endtask

  task automatic report_stall(input string what);
    $display("stalled at %0d ns: %s", $time, what);
    $display("SIMULATION FAILED");
    $fatal(1, "handshake timeout");
  endtask

  task automatic wait_start_bit();
    int waited;
    waited = 0;
    @(negedge sd_clk);
    while (!(cmd_line.oe && (cmd_line.out == 1'b0))) begin
      waited++;
      if (waited > 4) begin
        report_stall("no start bit on the CMD line after the enable rose");
      end
      @(negedge sd_clk);
    end
  endtask

  // Leaves off on the first cycle after the end bit
  task automatic capture_command(output logic [CMD_FRAME_BITS-1:0] seen);
    seen = '0;
    wait_start_bit();
    repeat (CMD_FRAME_BITS) begin
      expect_true(cmd_line.oe, "host released the CMD line inside its own frame");
      seen = {seen[CMD_FRAME_BITS-2:0], cmd_line.out};
      @(negedge sd_clk);
    end
  endtask

  // Card model replies once the host drives the line again
  task automatic card_reply(input logic long_rsp, input logic flip_crc, input logic [5:0] index,
                            output logic [RSP_LONG_BITS-1:0] frame);
    logic [RSP_LONG_BITS-1:0] shifted;
    logic [RSP_LONG_BITS-1:0] flip_mask;
    logic [127:0]             payload;
    logic [31:0]              rnd;
    int                       len;
    int                       waited;
    frame = '0;
    payload = '0;
    if (long_rsp) begin
      repeat (4) begin
        payload = {payload[95:0], next_random()};
      end
      // Start, direction, reserved ones, then the CID or CSD payload
      frame[135:128] = 8'h3f;
      frame[127:8] = payload[119:0];
      frame = with_crc(frame, RSP_LONG_BITS - 1 - RSP_LONG_HDR_BITS);
      len = RSP_LONG_BITS;
    end else begin
      frame[47:8] = {2'b00, index, next_random()};
      frame = with_crc(frame, RSP_SHORT_BITS - 1);
      len = RSP_SHORT_BITS;
    end
    if (flip_crc) begin
      rnd = next_random();
      flip_mask = '0;
      flip_mask[1] = 1'b1;
      frame = frame ^ (flip_mask << (rnd % 32'd7));
    end
    waited = 0;
    while (!cmd_line.oe) begin
      waited++;
      if (waited > TURN_CYCLES + 4) begin
        report_stall("host never drove the CMD line again after turnaround");
      end
      @(negedge sd_clk);
    end
    rnd = next_random();
    repeat (rnd[2:0]) @(negedge sd_clk);
    shifted = frame << (RSP_LONG_BITS - len);
    repeat (len) begin
      sd_cmd = shifted[RSP_LONG_BITS-1];
      shifted = shifted << 1;
      @(negedge sd_clk);
    end
    sd_cmd = CMD_IDLE_LEVEL;
  endtask

  task automatic run_command(input logic long_rsp, input logic flip_crc);
    sd_cmd_t                   next_cmd;
    logic [RSP_LONG_BITS-1:0]  expect_frame;
    logic [RSP_LONG_BITS-1:0]  reply;
    logic [CMD_FRAME_BITS-1:0] seen;
    logic [31:0]               rnd;
    rnd = next_random();
    next_cmd.index = rnd[5:0];
    next_cmd.arg = next_random();
    expect_frame = '0;
    expect_frame[47:8] = {2'b01, next_cmd.index, next_cmd.arg};
    expect_frame = with_crc(expect_frame, CMD_FRAME_BITS - 1);
    cmd = next_cmd;
    rsp_long = long_rsp;
    cmd_en = 1'b1;
    capture_command(seen);
    expect_true(seen == expect_frame[CMD_FRAME_BITS-1:0],
                $sformatf("command frame %h, expected %h", seen,
                          expect_frame[CMD_FRAME_BITS-1:0]));
    card_reply(long_rsp, flip_crc, next_cmd.index, reply);
    // Done follows the edge that took the last CRC bit by one cycle
    expect_true(rsp_done, "response done not high one cycle after the last CRC bit");
    // Captured bits run from the start bit to the last CRC bit
    expect_true(rsp.bits == (reply >> 1),
                $sformatf("response bits %h, expected %h", rsp.bits, reply >> 1));
    expect_true(rsp.crc_err == flip_crc,
                $sformatf("crc_err %b, expected %b", rsp.crc_err, flip_crc));
    @(negedge sd_clk);
    expect_true(rsp_done && (rsp.bits == (reply >> 1)),
                "response result not held while the enable is high");
    cmd_en = 1'b0;
    @(negedge sd_clk);
    expect_true(!rsp_done, "done still high after the enable dropped");
  endtask

  task automatic abort_command();
    sd_cmd_t     next_cmd;
    logic [31:0] rnd;
    rnd = next_random();
    next_cmd.index = rnd[5:0];
    // Low argument half is zero so a frame still being sent would show 0
    next_cmd.arg = next_random() & 32'hffff_0000;
    cmd = next_cmd;
    rsp_long = 1'b0;
    cmd_en = 1'b1;
    wait_start_bit();
    // Somewhere inside the argument
    repeat (CMD_FRAME_BITS / 2) @(negedge sd_clk);
    cmd_en = 1'b0;
    @(negedge sd_clk);
    expect_true(cmd_line.oe && cmd_line.out && !rsp_done,
                $sformatf("oe %b out %b done %b one cycle after abort",
                          cmd_line.oe, cmd_line.out, rsp_done));
    @(negedge sd_clk);
  endtask

  initial begin
    rst = 1'b1;
    cmd_en = 1'b0;
    cmd = '0;
    rsp_long = 1'b0;
    sd_cmd = CMD_IDLE_LEVEL;
    lcg_state = SEED;
    repeat (2) @(posedge sd_clk);
    @(negedge sd_clk);
    expect_true(cmd_line.oe && cmd_line.out && !rsp_done && !rsp.crc_err,
                $sformatf("after reset oe %b out %b done %b crc_err %b",
                          cmd_line.oe, cmd_line.out, rsp_done, rsp.crc_err));
    rst = 1'b0;
    @(negedge sd_clk);
    repeat (3) begin
      run_command(1'b0, 1'b0);
    end
    repeat (2) begin
      run_command(1'b1, 1'b0);
    end
    run_command(1'b0, 1'b1);
    run_command(1'b1, 1'b1);
    abort_command();
    // Next command after the abort runs normally
    run_command(1'b0, 1'b0);
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

//--- tb/sd_cmd_phy_asserts.sv
`timescale 1ns/1ps
// Line and handshake rules for sd_cmd_phy, bound into every instance
// TURN_CYCLES is taken from the bound phy
module sd_cmd_phy_asserts
  import sd_line_pkg::*;
#(
  parameter int TURN_CYCLES = 2
) (
  input logic     i_sd_clk,
  input logic     rst,
  input logic     i_cmd_en,
  input sd_line_t i_cmd_line,
  input logic     i_rsp_done,
  input logic     i_tx_done
);

  // Consecutive sampled cycles with the pad released
  logic [7:0] low_cnt;

  always_ff @(posedge i_sd_clk) begin
    if (rst) begin
      low_cnt <= '0;
    end else begin
      low_cnt <= i_cmd_line.oe ? '0 : low_cnt + 1'b1;
    end
  end

  // Release starts right after the end bit
  release_after_end_bit: assert property (@(posedge i_sd_clk) disable iff (rst)
    $fell(i_cmd_line.oe) |-> $past(i_tx_done))
    else $error("CMD line released without an end bit just before");

  // Only an abort may cut the turnaround short
  turnaround_length: assert property (@(posedge i_sd_clk) disable iff (rst)
    $rose(i_cmd_line.oe) && $past(i_cmd_en) |-> (low_cnt == 8'(TURN_CYCLES)))
    else $error("turnaround lasted %0d cycles instead of %0d", low_cnt, TURN_CYCLES);

  abort_to_idle: assert property (@(posedge i_sd_clk) disable iff (rst)
    !i_cmd_en |=> !i_rsp_done && i_cmd_line.oe && i_cmd_line.out)
    else $error("phy not idle one cycle after the enable dropped");

  done_with_line_driven: assert property (@(posedge i_sd_clk) disable iff (rst)
    i_rsp_done |-> i_cmd_line.oe && i_cmd_line.out)
    else $error("response done while the CMD line is not driven high");

endmodule

bind sd_cmd_phy sd_cmd_phy_asserts #(
  .TURN_CYCLES (TURN_CYCLES)
) asserts_i (
  .i_sd_clk   (i_sd_clk),
  .rst        (rst),
  .i_cmd_en   (i_cmd_en),
  .i_cmd_line (o_cmd_line),
  .i_rsp_done (o_rsp_done),
  .i_tx_done  (tx_done)
);

//--- source/sd_cmd_phy.sv
`timescale 1ns/1ps
// CMD channel of an SD host phy in SD bus mode, no data lines
// i_cmd and i_rsp_long must stay stable while i_cmd_en is high
module sd_cmd_phy
  import sd_cmd_pkg::*;
  import sd_line_pkg::*;
#(
  parameter int TURN_CYCLES = 2
) (
  input  logic     i_sd_clk,
  input  logic     rst,
  input  logic     i_cmd_en,
  input  sd_cmd_t  i_cmd,
  input  logic     i_rsp_long,
  output sd_line_t o_cmd_line,
  input  logic     i_sd_cmd,
  output sd_rsp_t  o_rsp,
  output logic     o_rsp_done
);

  logic     tx_start;
  logic     tx_done;
  logic     rx_start;
  logic     rx_done;
  logic     abort;
  sd_line_t tx_line;
  sd_line_t turn_line;

  sd_cmd_ctrl #(
    .TURN_CYCLES (TURN_CYCLES)
  ) ctrl_i (
    .i_sd_clk    (i_sd_clk),
    .rst         (rst),
    .i_cmd_en    (i_cmd_en),
    .i_tx_done   (tx_done),
    .i_rx_done   (rx_done),
    .o_tx_start  (tx_start),
    .o_rx_start  (rx_start),
    .o_abort     (abort),
    .o_turn_line (turn_line),
    .o_rsp_done  (o_rsp_done)
  );

  sd_cmd_tx tx_i (
    .i_sd_clk (i_sd_clk),
    .rst      (rst),
    .i_start  (tx_start),
    .i_abort  (abort),
    .i_cmd    (i_cmd),
    .o_line   (tx_line),
    .o_done   (tx_done)
  );

  sd_rsp_rx rx_i (
    .i_sd_clk (i_sd_clk),
    .rst      (rst),
    .i_start  (rx_start),
    .i_abort  (abort),
    .i_long   (i_rsp_long),
    .i_sd_cmd (i_sd_cmd),
    .o_rsp    (o_rsp),
    .o_done   (rx_done)
  );

  // Transmitter owns the pad only while it is sending
  assign o_cmd_line = tx_line.oe ? tx_line : turn_line;

endmodule

//--- source/sd_cmd_ctrl.sv
`timescale 1ns/1ps
// Sequences one command: send, turnaround, receive, then hold the result
// TURN_CYCLES must be at least 1; a low i_cmd_en aborts from any state
module sd_cmd_ctrl
  import sd_line_pkg::*;
#(
  parameter int TURN_CYCLES = 2
) (
  input  logic     i_sd_clk,
  input  logic     rst,
  input  logic     i_cmd_en,
  input  logic     i_tx_done,
  input  logic     i_rx_done,
  output logic     o_tx_start,
  output logic     o_rx_start,
  output logic     o_abort,
  output sd_line_t o_turn_line,
  output logic     o_rsp_done
);

  localparam int TW = (TURN_CYCLES > 1) ? $clog2(TURN_CYCLES) : 1;
  localparam logic [TW-1:0] TURN_LAST = TW'(TURN_CYCLES - 1);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_SEND,
    ST_TURN,
    ST_RECV,
    ST_DONE
  } state_t;

  state_t        state_q;
  logic [TW-1:0] turn_q;
  logic          tx_start_q;
  logic          turn_end;

  assign turn_end = (state_q == ST_TURN) && (turn_q == TURN_LAST);

  // One cycle only, the next edge takes the FSM back to idle
  assign o_abort    = !i_cmd_en && (state_q != ST_IDLE);
  assign o_tx_start = tx_start_q;
  // Armed in the last turnaround cycle so the first free cycle is sampled
  assign o_rx_start = turn_end;
  assign o_rsp_done = (state_q == ST_DONE);
  // Released only during turnaround
  assign o_turn_line = '{oe: (state_q != ST_TURN), out: CMD_IDLE_LEVEL};

  always_ff @(posedge i_sd_clk) begin
    if (rst) begin
      state_q    <= ST_IDLE;
      turn_q     <= '0;
      tx_start_q <= 1'b0;
    end else begin
      tx_start_q <= 1'b0;
      if (!i_cmd_en) begin
        state_q <= ST_IDLE;
      end else begin
        case (state_q)
          ST_IDLE: begin
            state_q    <= ST_SEND;
            tx_start_q <= 1'b1;
          end
          ST_SEND: begin
            if (i_tx_done) begin
              state_q <= ST_TURN;
              turn_q  <= '0;
            end
          end
          ST_TURN: begin
            if (turn_end) begin
              state_q <= ST_RECV;
            end else begin
              turn_q <= turn_q + 1'b1;
            end
          end
          ST_RECV: begin
            if (i_rx_done) begin
              state_q <= ST_DONE;
            end
          end
          ST_DONE: begin
            // Result held until the host drops the enable
            state_q <= ST_DONE;
          end
          default: begin
            state_q <= ST_IDLE;
          end
        endcase
      end
    end
  end

endmodule

//--- source/sd_rsp_rx.sv
`timescale 1ns/1ps
// Waits for the card start bit, then captures a short or long response
// No timeout while hunting; i_long must hold from i_start to o_done
module sd_rsp_rx
  import sd_cmd_pkg::*;
  import sd_line_pkg::*;
(
  input  logic    i_sd_clk,
  input  logic    rst,
  input  logic    i_start,
  input  logic    i_abort,
  input  logic    i_long,
  input  logic    i_sd_cmd,
  output sd_rsp_t o_rsp,
  output logic    o_done
);

  localparam int CNT_W = $clog2(RSP_LONG_BITS);

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_HUNT,
    RX_CAPT
  } rx_state_t;

  rx_state_t                state_q;
  // Index of the bit sampled on the coming edge while capturing
  logic [CNT_W-1:0]         idx_q;
  logic [CNT_W-1:0]         idx;
  logic [CNT_W-1:0]         cap_last;
  logic [CNT_W-1:0]         crc_first;
  logic [CNT_W-1:0]         hdr_len;
  logic [RSP_LONG_BITS-1:0] bits_q;
  logic                     crc_err_q;
  logic                     done_q;
  logic                     sampling;
  logic                     crc_en;
  logic [CRC7_BITS-1:0]     crc;
  logic [CRC7_BITS-1:0]     rx_crc;

  // End bit is never sampled, so the last index is two below the length
  assign cap_last  = i_long ? CNT_W'(RSP_LONG_BITS - 2) : CNT_W'(RSP_SHORT_BITS - 2);
  assign crc_first = i_long ? CNT_W'(RSP_LONG_BITS - 1 - CRC7_BITS) :
                              CNT_W'(RSP_SHORT_BITS - 1 - CRC7_BITS);
  assign hdr_len   = i_long ? CNT_W'(RSP_LONG_HDR_BITS) : '0;

  assign sampling = ((state_q == RX_HUNT) && (i_sd_cmd != CMD_IDLE_LEVEL)) ||
                    (state_q == RX_CAPT);
  assign idx      = (state_q == RX_CAPT) ? idx_q : '0;
  assign crc_en   = sampling && (idx >= hdr_len) && (idx < crc_first);
  // Received CRC field, completed by the bit on the line now
  assign rx_crc   = {bits_q[CRC7_BITS-2:0], i_sd_cmd};

  sd_crc7 crc_i (
    .i_sd_clk (i_sd_clk),
    .rst      (rst),
    .i_clear  (i_start),
    .i_en     (crc_en),
    .i_bit    (i_sd_cmd),
    .o_crc    (crc)
  );

  always_ff @(posedge i_sd_clk) begin
    if (rst) begin
      state_q   <= RX_IDLE;
      idx_q     <= '0;
      crc_err_q <= 1'b0;
      done_q    <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (i_abort) begin
        state_q <= RX_IDLE;
      end else begin
        case (state_q)
          RX_IDLE: begin
            if (i_start) begin
              state_q   <= RX_HUNT;
              crc_err_q <= 1'b0;
            end
          end
          RX_HUNT: begin
            // Start bit sits at index 0
            if (sampling) begin
              state_q <= RX_CAPT;
              idx_q   <= CNT_W'(1);
            end
          end
          RX_CAPT: begin
            idx_q <= idx_q + 1'b1;
            if (idx_q == cap_last) begin
              state_q   <= RX_IDLE;
              crc_err_q <= (rx_crc != crc);
              done_q    <= 1'b1;
            end
          end
          default: begin
            state_q <= RX_IDLE;
          end
        endcase
      end
    end
  end

  // Upper bits stay zero for a short response
  always_ff @(posedge i_sd_clk) begin
    if (i_start) begin
      bits_q <= '0;
    end else if (sampling) begin
      bits_q <= {bits_q[RSP_LONG_BITS-2:0], i_sd_cmd};
    end
  end

  assign o_rsp  = '{bits: bits_q, crc_err: crc_err_q};
  assign o_done = done_q;

endmodule

//--- source/sd_cmd_tx.sv
`timescale 1ns/1ps
// Shifts one 48-bit command frame onto the CMD line, MSB first
// i_cmd is taken on the i_start edge only
module sd_cmd_tx
  import sd_cmd_pkg::*;
  import sd_line_pkg::*;
(
  input  logic     i_sd_clk,
  input  logic     rst,
  input  logic     i_start,
  input  logic     i_abort,
  input  sd_cmd_t  i_cmd,
  output sd_line_t o_line,
  output logic     o_done
);

  localparam int CNT_W = $clog2(CMD_FRAME_BITS);
  localparam logic [CNT_W-1:0] LAST_CONTENT = CNT_W'(CMD_CONTENT_BITS - 1);
  localparam logic [CNT_W-1:0] FIRST_CRC = CNT_W'(CMD_CONTENT_BITS);
  localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(CMD_FRAME_BITS - 1);

  logic                        active_q;
  // Index of the frame bit now on the line
  logic [CNT_W-1:0]            bit_q;
  logic [CNT_W-1:0]            bit_next;
  logic [CMD_CONTENT_BITS-1:0] shift_q;
  sd_line_t                    line_q;
  logic                        done_q;
  logic [CRC7_BITS-1:0]        crc;
  logic                        crc_en;

  assign bit_next = bit_q + 1'b1;
  // Each content bit is folded as it leaves the shift register
  assign crc_en = active_q && (bit_next <= LAST_CONTENT);

  // Start bit is 0, so the cleared register already accounts for it
  sd_crc7 crc_i (
    .i_sd_clk (i_sd_clk),
    .rst      (rst),
    .i_clear  (i_start),
    .i_en     (crc_en),
    .i_bit    (shift_q[CMD_CONTENT_BITS-1]),
    .o_crc    (crc)
  );

  always_ff @(posedge i_sd_clk) begin
    if (rst) begin
      active_q <= 1'b0;
      bit_q    <= '0;
      line_q   <= '{oe: 1'b0, out: CMD_IDLE_LEVEL};
      done_q   <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (i_abort) begin
        active_q <= 1'b0;
        line_q   <= '{oe: 1'b0, out: CMD_IDLE_LEVEL};
      end else if (i_start) begin
        active_q <= 1'b1;
        bit_q    <= '0;
        line_q   <= '{oe: 1'b1, out: 1'b0};
      end else if (active_q) begin
        if (bit_q == LAST_BIT) begin
          // End bit has had its cycle, let go of the pad
          active_q <= 1'b0;
          line_q   <= '{oe: 1'b0, out: CMD_IDLE_LEVEL};
        end else begin
          bit_q      <= bit_next;
          line_q.out <= (bit_next == FIRST_CRC) ? crc[CRC7_BITS-1] :
                        shift_q[CMD_CONTENT_BITS-1];
          done_q     <= (bit_next == LAST_BIT);
        end
      end
    end
  end

  always_ff @(posedge i_sd_clk) begin
    if (i_start) begin
      // Direction, index, argument left after the start bit
      shift_q <= {1'b1, i_cmd.index, i_cmd.arg, 1'b0};
    end else if (active_q && (bit_next == FIRST_CRC)) begin
      // Remaining CRC bits followed by the end bit
      shift_q <= {crc[CRC7_BITS-2:0], 1'b1, {(CMD_CONTENT_BITS - CRC7_BITS){1'b0}}};
    end else if (active_q) begin
      shift_q <= {shift_q[CMD_CONTENT_BITS-2:0], 1'b0};
    end
  end

  assign o_line = line_q;
  assign o_done = done_q;

endmodule

//--- source/sd_crc7.sv
`timescale 1ns/1ps
// Serial CRC7, polynomial x^7 + x^3 + 1, one bit per enabled clock
// i_clear wins over i_en on the same edge
module sd_crc7
  import sd_cmd_pkg::*;
(
  input  logic                 i_sd_clk,
  input  logic                 rst,
  input  logic                 i_clear,
  input  logic                 i_en,
  input  logic                 i_bit,
  output logic [CRC7_BITS-1:0] o_crc
);

  logic [CRC7_BITS-1:0] crc_q;
  logic                 fb;

  assign fb = crc_q[CRC7_BITS-1] ^ i_bit;

  always_ff @(posedge i_sd_clk) begin
    if (rst || i_clear) begin
      crc_q <= '0;
    end else if (i_en) begin
      // Feedback into x^3 and x^0
      crc_q <= {crc_q[5:3], crc_q[2] ^ fb, crc_q[1:0], fb};
    end
  end

  assign o_crc = crc_q;

endmodule

//--- source/sd_line_pkg.sv
// Drive state of the CMD pad as seen from the host
// A released line floats to the idle level through the card pull-up
package sd_line_pkg;

  localparam logic CMD_IDLE_LEVEL = 1'b1;

  // oe high means the host drives out onto the pad
  typedef struct packed {
    logic oe;
    logic out;
  } sd_line_t;

endpackage

//--- source/sd_cmd_pkg.sv
// Frame formats and bit counts for the SD bus mode CMD line
// Lengths count every bit on the wire, start and end bits included
package sd_cmd_pkg;

  // Start, direction, index and argument, all under the CRC
  localparam int CMD_CONTENT_BITS = 40;
  localparam int CRC7_BITS = 7;
  localparam int CMD_FRAME_BITS = 48;

  // R1/R3/R6/R7 style responses
  localparam int RSP_SHORT_BITS = 48;
  // R2 with CID or CSD payload
  localparam int RSP_LONG_BITS = 136;
  // Start, direction and reserved bits ahead of the long payload
  localparam int RSP_LONG_HDR_BITS = 8;

  typedef struct packed {
    logic [5:0]  index;
    logic [31:0] arg;
  } sd_cmd_t;

  // Bits are right aligned, start bit through last CRC bit
  typedef struct packed {
    logic [RSP_LONG_BITS-1:0] bits;
    logic                     crc_err;
  } sd_rsp_t;

endpackage
